// ==== design/r24bb_pkg.sv ====
`default_nettype none

package r24bb_pkg;

    ////////////////////////////////////////
    // AXI4-Lite register bus
    ////////////////////////////////////////

    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    localparam logic [AXIL_DATA_W-1:0] R24BB_ID = 32'h5242_2401; // Board and revision tag

    // Byte offsets inside the slave
    typedef enum logic [AXIL_ADDR_W-1:0] {
        REG_ID        = 8'h00,
        REG_INA_CTRL  = 8'h04,
        REG_INB_CTRL  = 8'h08,
        REG_FRAME_CNT = 8'h0C
    } reg_addr_e;

    // Channel control register layout
    localparam int ATT_W        = 2;
    localparam int LED_W        = 3; // Red, green, blue from MSB down
    localparam int CTRL_ATT_LSB = 0;
    localparam int CTRL_AMP_BIT = 2;
    localparam int CTRL_LED_LSB = 3;
    localparam int CTRL_W       = CTRL_LED_LSB + LED_W; // Upper bits read zero

    ////////////////////////////////////////
    // I2C expander link
    ////////////////////////////////////////

    localparam int IOEXP_W = 16; // Port 1 in the upper byte
    localparam logic [6:0] IOEXP_DEV_ADDR = 7'h20;

    localparam int QTR_DIV        = 5; // Clocks per quarter bit
    localparam int QTR_CNT_W      = $clog2(QTR_DIV);
    localparam int FRAME_GAP_QTRS = 8;
    localparam int GAP_CNT_W      = $clog2(FRAME_GAP_QTRS + 1);
    localparam int FRAME_CNT_W    = 16;

    typedef enum logic [2:0] {IDLE, START, SHIFT, ACK, STOP, GAP} ioexp_state_e;

endpackage

`default_nettype wire

// ==== design/axil_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module axil_regs (
    input  logic                                clk_i,
    input  logic                                rst_i,
    // Write address and data
    input  logic [r24bb_pkg::AXIL_ADDR_W-1:0]   s_awaddr_i,
    input  logic                                s_awvalid_i,
    output logic                                s_awready_o,
    input  logic [r24bb_pkg::AXIL_DATA_W-1:0]   s_wdata_i,
    input  logic [r24bb_pkg::AXIL_DATA_W/8-1:0] s_wstrb_i,
    input  logic                                s_wvalid_i,
    output logic                                s_wready_o,
    output logic [1:0]                          s_bresp_o,
    output logic                                s_bvalid_o,
    input  logic                                s_bready_i,
    // Read channel
    input  logic [r24bb_pkg::AXIL_ADDR_W-1:0]   s_araddr_i,
    input  logic                                s_arvalid_i,
    output logic                                s_arready_o,
    output logic [r24bb_pkg::AXIL_DATA_W-1:0]   s_rdata_o,
    output logic [1:0]                          s_rresp_o,
    output logic                                s_rvalid_o,
    input  logic                                s_rready_i,
    // Sequencer side
    input  logic                                frame_done_i,
    output logic [r24bb_pkg::ATT_W-1:0]         ina_att_o,
    output logic                                ina_amp_en_o,
    output logic [r24bb_pkg::LED_W-1:0]         ina_led_o,
    output logic [r24bb_pkg::ATT_W-1:0]         inb_att_o,
    output logic                                inb_amp_en_o,
    output logic [r24bb_pkg::LED_W-1:0]         inb_led_o
);
    import r24bb_pkg::*;

    logic                   wr_acc;
    logic                   rd_acc;
    logic [CTRL_W-1:0]      ina_ctrl_q;
    logic [CTRL_W-1:0]      inb_ctrl_q;
    logic [FRAME_CNT_W-1:0] frame_cnt_q;
    logic [AXIL_DATA_W-1:0] rd_mux;

    // Accept only when the previous response has gone
    assign wr_acc      = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
    assign rd_acc      = s_arvalid_i && !s_rvalid_o;
    assign s_awready_o = wr_acc;
    assign s_wready_o  = wr_acc; // Both halves taken together
    assign s_arready_o = rd_acc;
    assign s_bresp_o   = AXI_RESP_OKAY;
    assign s_rresp_o   = AXI_RESP_OKAY;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s_bvalid_o  <= 1'b0;
            s_rvalid_o  <= 1'b0;
            ina_ctrl_q  <= '0;
            inb_ctrl_q  <= '0;
            frame_cnt_q <= '0;
        end else begin
            if (wr_acc) s_bvalid_o <= 1'b1;
            else if (s_bready_i) s_bvalid_o <= 1'b0;
            if (rd_acc) s_rvalid_o <= 1'b1;
            else if (s_rready_i) s_rvalid_o <= 1'b0;
            // All writable bits sit in byte 0
            if (wr_acc && s_wstrb_i[0]) begin
                case (reg_addr_e'(s_awaddr_i))
                    REG_INA_CTRL: ina_ctrl_q <= s_wdata_i[CTRL_W-1:0];
                    REG_INB_CTRL: inb_ctrl_q <= s_wdata_i[CTRL_W-1:0];
                    default: ; // ID, count and holes are read-only
                endcase
            end
            if (frame_done_i) frame_cnt_q <= frame_cnt_q + 1'b1; // Wraps
        end
    end

    always_comb begin
        rd_mux = '0;
        case (reg_addr_e'(s_araddr_i))
            REG_ID:        rd_mux = R24BB_ID;
            REG_INA_CTRL:  rd_mux[CTRL_W-1:0] = ina_ctrl_q;
            REG_INB_CTRL:  rd_mux[CTRL_W-1:0] = inb_ctrl_q;
            REG_FRAME_CNT: rd_mux[FRAME_CNT_W-1:0] = frame_cnt_q;
            default:       rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rd_acc) s_rdata_o <= rd_mux; // Held while rvalid waits
    end

    // Field split toward the word packer
    assign ina_att_o    = ina_ctrl_q[CTRL_ATT_LSB +: ATT_W];
    assign ina_amp_en_o = ina_ctrl_q[CTRL_AMP_BIT];
    assign ina_led_o    = ina_ctrl_q[CTRL_LED_LSB +: LED_W];
    assign inb_att_o    = inb_ctrl_q[CTRL_ATT_LSB +: ATT_W];
    assign inb_amp_en_o = inb_ctrl_q[CTRL_AMP_BIT];
    assign inb_led_o    = inb_ctrl_q[CTRL_LED_LSB +: LED_W];

    bvalid_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o);
    rvalid_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o));

endmodule

`default_nettype wire

// ==== design/ioexp_word.sv ====
`timescale 1ns/10ps
`default_nettype none

module ioexp_word (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic [r24bb_pkg::ATT_W-1:0]   ina_att_i,
    input  logic                          ina_amp_en_i,
    input  logic [r24bb_pkg::LED_W-1:0]   ina_led_i,
    input  logic [r24bb_pkg::ATT_W-1:0]   inb_att_i,
    input  logic                          inb_amp_en_i,
    input  logic [r24bb_pkg::LED_W-1:0]   inb_led_i,
    input  logic                          dor_a_i,
    input  logic                          dor_b_i,
    input  logic                          frame_start_i,
    output logic [r24bb_pkg::IOEXP_W-1:0] word_o
);
    import r24bb_pkg::*;

    logic [1:0]       ovr_q; // Bit 0 channel A, bit 1 channel B
    logic [LED_W-1:0] ina_led_m;
    logic [LED_W-1:0] inb_led_m;
    logic [7:0]       port0;
    logic [7:0]       port1;

    // Sticky until the frame that shows it starts
    always_ff @(posedge clk_i) begin
        if (rst_i) ovr_q <= '0;
        else ovr_q <= (frame_start_i ? 2'b00 : ovr_q) | {dor_b_i, dor_a_i};
    end

    // Overrange lights red only
    assign ina_led_m = ovr_q[0] ? 3'b100 : ina_led_i;
    assign inb_led_m = ovr_q[1] ? 3'b100 : inb_led_i;

    assign port0 = {1'b0, ina_amp_en_i, ina_att_i[1], ina_att_i[0],
                    1'b0, inb_amp_en_i, inb_att_i[1], inb_att_i[0]};
    assign port1 = {1'b0, ina_led_m[2], inb_led_m[2], 1'b0,
                    inb_led_m[1], inb_led_m[0], ina_led_m[1], ina_led_m[0]};

    // Frozen for the whole frame
    always_ff @(posedge clk_i) begin
        if (frame_start_i) word_o <= {port1, port0};
    end

endmodule

`default_nettype wire

// ==== design/ioexp_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module ioexp_timer (
    input  logic clk_i,
    input  logic rst_i,
    input  logic gap_start_i,
    output logic qtr_tick_o,
    output logic gap_done_o
);
    import r24bb_pkg::*;

    logic [QTR_CNT_W-1:0] qtr_cnt_q;
    logic [GAP_CNT_W-1:0] gap_cnt_q;
    logic                 gap_run_q;

    assign qtr_tick_o = (qtr_cnt_q == QTR_CNT_W'(QTR_DIV - 1));
    assign gap_done_o = qtr_tick_o && gap_run_q && (gap_cnt_q == GAP_CNT_W'(1)); // Last tick

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            qtr_cnt_q <= '0;
            gap_cnt_q <= GAP_CNT_W'(FRAME_GAP_QTRS); // First gap runs out of reset
            gap_run_q <= 1'b1;
        end else begin
            qtr_cnt_q <= qtr_tick_o ? '0 : qtr_cnt_q + 1'b1;
            if (gap_start_i) begin
                gap_cnt_q <= GAP_CNT_W'(FRAME_GAP_QTRS);
                gap_run_q <= 1'b1;
            end else if (qtr_tick_o && gap_run_q) begin
                gap_cnt_q <= gap_cnt_q - 1'b1;
                if (gap_cnt_q == GAP_CNT_W'(1)) gap_run_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/ioexp_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module ioexp_fsm (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          qtr_tick_i,
    input  logic                          gap_done_i,
    input  logic [r24bb_pkg::IOEXP_W-1:0] word_i,
    output logic                          frame_start_o,
    output logic                          frame_done_o,
    output logic                          gap_start_o,
    output logic                          sclk_o,
    output logic                          sdata_o
);
    import r24bb_pkg::*;

    ioexp_state_e state_q;
    logic [1:0]   qph_q;  // Quarter within the bit
    logic [2:0]   bit_q;
    logic [1:0]   byte_q; // 0 address, 1 port 0, 2 port 1
    logic [7:0]   shreg_q;
    logic         last_qtr;
    logic         idle_gap;
    logic         sclk_d;
    logic         sdata_d;

    assign last_qtr = qtr_tick_i && (qph_q == 2'd3);
    assign idle_gap = (state_q == IDLE) || (state_q == GAP);

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q       <= IDLE;
            qph_q         <= '0;
            bit_q         <= '0;
            byte_q        <= '0;
            frame_start_o <= 1'b0;
            frame_done_o  <= 1'b0;
            gap_start_o   <= 1'b0;
        end else begin
            frame_start_o <= 1'b0;
            frame_done_o  <= 1'b0;
            gap_start_o   <= 1'b0;
            if (qtr_tick_i) qph_q <= qph_q + 1'b1;
            case (state_q)
                IDLE, GAP: if (gap_done_i) begin
                    state_q       <= START;
                    qph_q         <= '0;
                    byte_q        <= '0;
                    frame_start_o <= 1'b1; // Word packer snapshots here
                end
                START: if (last_qtr) begin
                    state_q <= SHIFT;
                    bit_q   <= '0;
                end
                SHIFT: if (last_qtr) begin
                    if (bit_q == 3'd7) state_q <= ACK;
                    bit_q <= bit_q + 1'b1;
                end
                ACK: if (last_qtr) begin
                    if (byte_q == 2'd2) begin
                        state_q <= STOP;
                    end else begin
                        state_q <= SHIFT;
                        byte_q  <= byte_q + 1'b1;
                        bit_q   <= '0;
                    end
                end
                STOP: if (last_qtr) begin
                    state_q      <= GAP;
                    frame_done_o <= 1'b1;
                    gap_start_o  <= 1'b1;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Address byte, then port 0, then port 1
    always_ff @(posedge clk_i) begin
        if (idle_gap && gap_done_i) shreg_q <= {IOEXP_DEV_ADDR, 1'b0};
        else if (last_qtr && state_q == SHIFT) shreg_q <= {shreg_q[6:0], 1'b0};
        else if (last_qtr && state_q == ACK)
            shreg_q <= (byte_q == 2'd0) ? word_i[IOEXP_W/2-1:0] : word_i[IOEXP_W-1:IOEXP_W/2];
    end

    ////////////////////////////////////////
    // Line levels
    ////////////////////////////////////////

    always_comb begin
        sclk_d  = 1'b1;
        sdata_d = 1'b1;
        case (state_q)
            START: begin
                sclk_d  = (qph_q != 2'd3);
                sdata_d = (qph_q == 2'd0); // Falls with sclk high
            end
            SHIFT: begin
                sclk_d  = qph_q[1];
                sdata_d = (qph_q == 2'd0) ? sdata_o : shreg_q[7];
            end
            ACK: begin
                sclk_d  = qph_q[1];
                sdata_d = (qph_q == 2'd0) ? sdata_o : 1'b1; // Released, never sampled
            end
            STOP: begin
                sclk_d  = qph_q[1];
                sdata_d = (qph_q == 2'd0) ? sdata_o : (qph_q == 2'd3);
            end
            default: ; // Idle bus
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sclk_o  <= 1'b1;
            sdata_o <= 1'b1;
        end else begin
            sclk_o  <= sclk_d;
            sdata_o <= sdata_d;
        end
    end

    // Outputs lag state by one clock
    sdata_low_a: assert property (@(posedge clk_i) disable iff (rst_i)
        $changed(sdata_o) && !($past(state_q) inside {START, STOP})
            |-> !sclk_o && !$past(sclk_o));

endmodule

`default_nettype wire

// ==== design/r24bb_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module r24bb_ctrl_top (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [r24bb_pkg::AXIL_ADDR_W-1:0]   s_awaddr_i,
    input  logic                                s_awvalid_i,
    output logic                                s_awready_o,
    input  logic [r24bb_pkg::AXIL_DATA_W-1:0]   s_wdata_i,
    input  logic [r24bb_pkg::AXIL_DATA_W/8-1:0] s_wstrb_i,
    input  logic                                s_wvalid_i,
    output logic                                s_wready_o,
    output logic [1:0]                          s_bresp_o,
    output logic                                s_bvalid_o,
    input  logic                                s_bready_i,
    input  logic [r24bb_pkg::AXIL_ADDR_W-1:0]   s_araddr_i,
    input  logic                                s_arvalid_i,
    output logic                                s_arready_o,
    output logic [r24bb_pkg::AXIL_DATA_W-1:0]   s_rdata_o,
    output logic [1:0]                          s_rresp_o,
    output logic                                s_rvalid_o,
    input  logic                                s_rready_i,
    input  logic                                dor_a_i,
    input  logic                                dor_b_i,
    output logic                                ioexp_sclk_o,
    output logic                                ioexp_sdata_o
);
    import r24bb_pkg::*;

    logic [ATT_W-1:0]   ina_att, inb_att;
    logic               ina_amp_en, inb_amp_en;
    logic [LED_W-1:0]   ina_led, inb_led;
    logic [IOEXP_W-1:0] ioexp_word_w;
    logic               frame_start, frame_done, gap_start;
    logic               qtr_tick, gap_done;

    axil_regs u_regs (.*, .frame_done_i(frame_done),
        .ina_att_o(ina_att), .ina_amp_en_o(ina_amp_en), .ina_led_o(ina_led),
        .inb_att_o(inb_att), .inb_amp_en_o(inb_amp_en), .inb_led_o(inb_led));

    ioexp_word u_word (.clk_i, .rst_i, .dor_a_i, .dor_b_i, .frame_start_i(frame_start),
        .ina_att_i(ina_att), .ina_amp_en_i(ina_amp_en), .ina_led_i(ina_led),
        .inb_att_i(inb_att), .inb_amp_en_i(inb_amp_en), .inb_led_i(inb_led),
        .word_o(ioexp_word_w));

    ioexp_timer u_timer (.clk_i, .rst_i, .gap_start_i(gap_start),
        .qtr_tick_o(qtr_tick), .gap_done_o(gap_done));

    ioexp_fsm u_fsm (.clk_i, .rst_i, .qtr_tick_i(qtr_tick), .gap_done_i(gap_done),
        .word_i(ioexp_word_w), .frame_start_o(frame_start), .frame_done_o(frame_done),
        .gap_start_o(gap_start), .sclk_o(ioexp_sclk_o), .sdata_o(ioexp_sdata_o));

endmodule

`default_nettype wire

// ==== verification/tb_r24bb_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_r24bb_ctrl;
    import r24bb_pkg::*;

    localparam int AXI_TIMEOUT   = 64;   // Cycles per bus handshake
    localparam int FRAME_TIMEOUT = 1000; // Cycles allowed per decoded frame

    logic        clk;
    logic        rst;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        dor_a;
    logic        dor_b;
    logic        sclk;
    logic        sdata;

    logic [15:0] lfsr_q;
    int          err_cnt;
    int          pass_tests;
    int          fail_tests;
    logic [5:0]  ina_set;      // Last value written to each channel
    logic [5:0]  inb_set;
    logic        rx_bits[$];   // Bits sampled inside the current frame
    logic [23:0] frames[$];    // Address, port 0, port 1
    logic        in_frame;
    logic        prev_sclk;
    logic        prev_sdata;

    r24bb_ctrl_top dut (
        .clk_i(clk), .rst_i(rst),
        .s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o(awready),
        .s_wdata_i(wdata), .s_wstrb_i(wstrb), .s_wvalid_i(wvalid), .s_wready_o(wready),
        .s_bresp_o(bresp), .s_bvalid_o(bvalid), .s_bready_i(bready),
        .s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o(arready),
        .s_rdata_o(rdata), .s_rresp_o(rresp), .s_rvalid_o(rvalid), .s_rready_i(rready),
        .dor_a_i(dor_a), .dor_b_i(dor_b),
        .ioexp_sclk_o(sclk), .ioexp_sdata_o(sdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q); // One step per bit
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Expected expander word, port 1 in the upper byte
    function automatic logic [15:0] ref_ioexp_word(input logic [5:0] a_ctrl,
            input logic [5:0] b_ctrl, input logic ovr_a, input logic ovr_b);
        logic [2:0] a_led;
        logic [2:0] b_led;
        logic [7:0] port0;
        logic [7:0] port1;
        a_led = ovr_a ? 3'b100 : a_ctrl[CTRL_LED_LSB +: 3]; // Overrange means red only
        b_led = ovr_b ? 3'b100 : b_ctrl[CTRL_LED_LSB +: 3];
        port0 = {1'b0, a_ctrl[CTRL_AMP_BIT], a_ctrl[CTRL_ATT_LSB + 1], a_ctrl[CTRL_ATT_LSB],
                 1'b0, b_ctrl[CTRL_AMP_BIT], b_ctrl[CTRL_ATT_LSB + 1], b_ctrl[CTRL_ATT_LSB]};
        port1 = {1'b0, a_led[2], b_led[2], 1'b0, b_led[1], b_led[0], a_led[1], a_led[0]};
        return {port1, port0};
    endfunction

    function automatic logic [15:0] word_of(input logic [23:0] f);
        return {f[7:0], f[15:8]};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Error %s: expected 0x%0h, actual 0x%0h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_tests++;
            $display("PASS %s", name);
        end else begin
            fail_tests++;
            $display("FAIL %s with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    ////////////////////////////////////////
    // AXI4-Lite master
    ////////////////////////////////////////

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
        int   cyc;
        logic acc;
        cyc = 0;
        acc = 1'b0;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        while (!acc && cyc < AXI_TIMEOUT) begin
            @(posedge clk); // Readies as this edge takes them
            acc = awready || wready;
            cyc++;
        end
        if (acc) begin
            check_eq("awready", 1, awready);
            check_eq("wready", 1, wready);
        end
        @(negedge clk);
        if (acc) begin
            check_eq("bvalid", 1, bvalid); // One cycle after acceptance
            check_eq("bresp", 0, bresp);
            check_eq("awready_blocked", 0, awready); // Response still pending
            check_eq("wready_blocked", 0, wready);
        end else begin
            $display("Timeout: write to offset 0x%0h never accepted", addr);
            err_cnt++;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        int   cyc;
        logic acc;
        cyc  = 0;
        acc  = 1'b0;
        data = 'x;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        while (!acc && cyc < AXI_TIMEOUT) begin
            @(posedge clk);
            acc = arready;
            cyc++;
        end
        @(negedge clk);
        if (acc) begin
            check_eq("rvalid", 1, rvalid); // Data one cycle after acceptance
            check_eq("rresp", 0, rresp);
            check_eq("arready_blocked", 0, arready);
            data = rdata;
        end else begin
            $display("Timeout: read of offset 0x%0h never accepted", addr);
            err_cnt++;
        end
        arvalid = 1'b0;
        @(negedge clk);
        rready = 1'b0;
    endtask

    ////////////////////////////////////////
    // I2C frame decoder
    ////////////////////////////////////////

    // 27 slots plus the clock rise inside the stop
    task automatic store_frame();
        logic [23:0] f;
        f = '0;
        check_eq("frame_length", 28, rx_bits.size());
        for (int i = 0; i < 8; i++) begin
            f[23 - i] = rx_bits[i];       // Address, MSB first
            f[15 - i] = rx_bits[9 + i];   // Port 0
            f[7 - i]  = rx_bits[18 + i];  // Port 1
        end
        check_eq("ack_slots", 3'b111, {rx_bits[8], rx_bits[17], rx_bits[26]});
        frames.push_back(f);
    endtask

    // Line levels are settled by the falling clock edge
    always @(negedge clk) begin
        if (rst) begin
            in_frame = 1'b0;
        end else if (prev_sclk === 1'b1 && sclk === 1'b1) begin
            if (prev_sdata === 1'b1 && sdata === 1'b0) begin // Start
                in_frame = 1'b1;
                rx_bits.delete();
            end else if (prev_sdata === 1'b0 && sdata === 1'b1 && in_frame) begin
                in_frame = 1'b0; // Stop
                store_frame();
            end
        end else if (prev_sclk === 1'b0 && sclk === 1'b1 && in_frame) begin
            rx_bits.push_back(sdata);
        end
        prev_sclk  = sclk;
        prev_sdata = sdata;
    end

    task automatic wait_frames(input int target);
        int cyc;
        cyc = 0;
        while (frames.size() < target && cyc < FRAME_TIMEOUT * 3) begin
            @(negedge clk);
            cyc++;
        end
        if (frames.size() < target) begin
            $display("Timeout: only %0d of %0d expander frames decoded", frames.size(), target);
            err_cnt++;
        end
    endtask

    // One-cycle overrange pulse on a channel set to green
    task automatic check_overrange(input logic chan_b, input string name);
        logic [31:0] r;
        logic [15:0] plain;
        logic [15:0] flagged;
        logic [15:0] seen;
        int          n;
        int          hit;
        r = rand_bits(3);
        if (chan_b) inb_set = {3'b010, r[2:0]};
        else ina_set = {3'b010, r[2:0]};
        axil_write(chan_b ? REG_INB_CTRL : REG_INA_CTRL, {26'd0, (chan_b ? inb_set : ina_set)});
        plain   = ref_ioexp_word(ina_set, inb_set, 1'b0, 1'b0);
        flagged = ref_ioexp_word(ina_set, inb_set, !chan_b, chan_b);
        wait_frames(frames.size() + 1); // Later frames all carry the new setting
        n = frames.size();
        @(negedge clk);
        if (chan_b) dor_b = 1'b1;
        else dor_a = 1'b1;
        @(negedge clk);
        dor_a = 1'b0;
        dor_b = 1'b0;
        wait_frames(n + 3); // Frame in flight, flagged one, plain one
        hit  = (word_of(frames[n]) === flagged) ? n : n + 1;
        seen = word_of(frames[hit]);
        check_eq({name, "_flagged"}, flagged, seen);
        check_eq({name, "_cleared"}, plain, word_of(frames[hit + 1]));
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] rd;
        logic [31:0] a_val;
        logic [31:0] b_val;
        logic [31:0] cnt0;
        logic [31:0] cnt1;
        int          n;
        int          errs;
        lfsr_q     = 16'd14059;
        err_cnt    = 0;
        pass_tests = 0;
        fail_tests = 0;
        ina_set    = '0;
        inb_set    = '0;
        rst        = 1'b1;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        dor_a      = 1'b0;
        dor_b      = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        errs = err_cnt;
        axil_read(REG_ID, rd);
        check_eq("id_read", R24BB_ID, rd);
        axil_read(8'h10, rd); // Hole in the map
        check_eq("unmapped_read", 0, rd);
        finish_test("id_read", errs);

        errs = err_cnt;
        repeat (4) begin
            a_val = rand_bits(32);
            b_val = rand_bits(32);
            axil_write(REG_INA_CTRL, a_val);
            axil_write(REG_INB_CTRL, b_val);
            axil_read(REG_INA_CTRL, rd);
            check_eq("ina_readback", a_val & 32'h3F, rd); // Bits 5..0 only
            axil_read(REG_INB_CTRL, rd);
            check_eq("inb_readback", b_val & 32'h3F, rd);
        end
        ina_set = a_val[5:0];
        inb_set = b_val[5:0];
        finish_test("ctrl_readback", errs);

        errs = err_cnt;
        repeat (3) begin
            ina_set = 6'(rand_bits(6));
            inb_set = 6'(rand_bits(6));
            axil_write(REG_INA_CTRL, {26'd0, ina_set});
            axil_write(REG_INB_CTRL, {26'd0, inb_set});
            n = frames.size();
            wait_frames(n + 2); // Second frame surely started after the writes
            check_eq("frame_addr", {IOEXP_DEV_ADDR, 1'b0}, frames[n + 1][23:16]);
            check_eq("frame_word", ref_ioexp_word(ina_set, inb_set, 1'b0, 1'b0),
                     word_of(frames[n + 1]));
        end
        finish_test("frame_word", errs);

        errs = err_cnt;
        check_overrange(1'b0, "dor_a");
        check_overrange(1'b1, "dor_b");
        finish_test("overrange", errs);

        errs = err_cnt;
        axil_read(REG_FRAME_CNT, cnt0);
        n = frames.size();
        wait_frames(n + 2); // Count of the first stop has landed by the second
        axil_read(REG_FRAME_CNT, cnt1);
        check_eq("frame_count_rises", 1, cnt1 > cnt0);
        finish_test("frame_count", errs);

        errs = err_cnt;
        axil_write(REG_ID, rand_bits(32));
        axil_read(REG_ID, rd);
        check_eq("id_readonly", R24BB_ID, rd);
        finish_test("id_readonly", errs);

        $display("Tests: %0d passed, %0d failed, %0d errors", pass_tests, fail_tests, err_cnt);
        if (err_cnt == 0 && fail_tests == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/r24bb_pkg.sv
design/axil_regs.sv
design/ioexp_word.sv
design/ioexp_timer.sv
design/ioexp_fsm.sv
design/r24bb_ctrl_top.sv
verification/tb_r24bb_ctrl.sv
